//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_fetch_stage
OBJ_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing \
   --top-module "$TOP" \
   -Mdir "$OBJ_DIR" \
   -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

if [ ! -x "$OBJ_DIR/V$TOP" ]; then
   echo "Simulation executable $OBJ_DIR/V$TOP is missing"
   exit 1
fi

sim_out=$("./$OBJ_DIR/V$TOP" 2>&1)
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
   exit 0
fi
exit 1

//--- sim/tb_fetch_stage.sv
`default_nettype none

// Self-checking testbench for the instruction fetch stage
// A reference model of PC, IF/ID registers and memory image is compared on every rising edge
module tb_fetch_stage;

   localparam int CLK_PERIOD  = 20;
   localparam int IMG_A       = 64;            // Words in the first program image
   localparam int IMG_B       = 16;            // Words in the reload image
   localparam int WORD_CYCLES = 5;             // Four strobes plus the write gap
   // Cycle budget of reset and all six tests
   localparam int TEST_CYCLES = 6 + (IMG_A * WORD_CYCLES + 2) + 66 + 41 + 42 + 12
                                + (IMG_B * WORD_CYCLES + 2) + 25;
   localparam int MARGIN      = 100;
   localparam logic [31:0] NOP = 32'h0000_0000;   // sll $0,$0,0

   logic        i_clk;
   logic        i_rst;
   logic        i_prog_mode;
   logic        i_byte_stb;
   logic [7:0]  i_byte;
   logic        i_if_id_we;
   logic        i_flush;
   logic        i_branch_taken;
   logic [31:0] i_branch_target;
   logic        i_jump;
   logic [31:0] i_jump_target;
   logic [31:0] o_instr;
   logic [31:0] o_pc4;
   logic        o_running;

   logic [31:0] model_mem [0:1023];            // Expected RAM contents
   logic [31:0] image [0:63];                  // Image being loaded
   logic [31:0] m_pc;                          // Model PC
   logic [31:0] m_instr;                       // Model IF/ID instruction
   logic [31:0] m_pc4;                         // Model IF/ID PC+4
   logic        m_run;                         // Model run flag
   logic        model_live;                    // Set once reset has been seen
   integer      seed = 32'hdff8_ea9f;
   logic [31:0] rnd;
   logic [31:0] bt;
   logic [31:0] jt;
   int          check_count    = 0;
   int          compare_errors = 0;            // Mismatches seen on clock edges
   int          direct_checks  = 0;
   int          direct_errors  = 0;            // Mismatches of the reset checks
   int          mark           = 0;            // Error total at the start of a test

   fetch_stage DUT (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_prog_mode     (i_prog_mode),
      .i_byte_stb      (i_byte_stb),
      .i_byte          (i_byte),
      .i_if_id_we      (i_if_id_we),
      .i_flush         (i_flush),
      .i_branch_taken  (i_branch_taken),
      .i_branch_target (i_branch_target),
      .i_jump          (i_jump),
      .i_jump_target   (i_jump_target),
      .o_instr         (o_instr),
      .o_pc4           (o_pc4),
      .o_running       (o_running)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
      $display("Timeout: the tests did not finish within the cycle budget");
      $display("test failed");
      $finish;
   end

   // Next {PC, IF/ID instruction, IF/ID PC+4} for one clock edge
   function automatic logic [95:0] expected_fetch(
      input logic run, input logic we, input logic flush,
      input logic br, input logic [31:0] br_tgt,
      input logic j, input logic [31:0] j_tgt,
      input logic [31:0] pc, input logic [31:0] instr, input logic [31:0] pc4);
      logic [31:0] npc;
      logic [31:0] ninstr;
      logic [31:0] npc4;
      npc    = pc;                             // Stall holds all three
      ninstr = instr;
      npc4   = pc4;
      if (!run) begin
         npc = 32'h0;                          // Parked at 0 while loading
      end else if (we) begin
         if (br)
            npc = br_tgt;                      // Branch beats jump
         else if (j)
            npc = j_tgt;
         else
            npc = pc + 32'd4;
         npc4   = pc + 32'd4;
         ninstr = flush ? NOP : model_mem[pc[11:2]];
      end
      return {npc, ninstr, npc4};
   endfunction

   // Compare DUT outputs with the model before the model advances
   always @(posedge i_clk) begin
      if (model_live) begin
         check_count++;
         if (o_running !== m_run) begin
            $display("CHECK FAILED o_running expected %0h actual %0h", m_run, o_running);
            compare_errors++;
         end
         if (o_running === 1'b1) begin
            if (o_instr !== m_instr) begin
               $display("CHECK FAILED o_instr expected %08h actual %08h", m_instr, o_instr);
               compare_errors++;
            end
            if (o_pc4 !== m_pc4) begin
               $display("CHECK FAILED o_pc4 expected %08h actual %08h", m_pc4, o_pc4);
               compare_errors++;
            end
         end
      end
      if (i_rst) begin
         m_pc       = 32'h0;
         m_instr    = NOP;
         m_pc4      = 32'h0;
         m_run      = 1'b0;
         model_live = 1'b1;
      end else begin
         {m_pc, m_instr, m_pc4} = expected_fetch(m_run, i_if_id_we, i_flush,
            i_branch_taken, i_branch_target, i_jump, i_jump_target, m_pc, m_instr, m_pc4);
         m_run = ~i_prog_mode;                 // Registered inverse of programming mode
      end
   end

   // One cycle of hazard and control inputs
   task automatic drive_cycle(input logic we, input logic flush, input logic br,
                              input logic [31:0] br_tgt, input logic j,
                              input logic [31:0] j_tgt);
      i_if_id_we      = we;
      i_flush         = flush;
      i_branch_taken  = br;
      i_branch_target = br_tgt;
      i_jump          = j;
      i_jump_target   = j_tgt;
      @(negedge i_clk);
   endtask

   // Four little-endian byte strobes and the idle cycle for LD_WRITE
   task automatic send_word(input logic [31:0] word, input logic [9:0] idx);
      logic [31:0] sh;
      sh = word;
      for (int b = 0; b < 4; b++) begin
         i_byte_stb = 1'b1;
         i_byte     = sh[7:0];
         sh         = sh >> 8;
         @(negedge i_clk);
      end
      i_byte_stb = 1'b0;
      i_byte     = 8'h00;
      @(negedge i_clk);                        // Word lands in RAM at the end of this cycle
      model_mem[idx] = word;
   endtask

   task automatic load_image(input int count);
      i_prog_mode = 1'b1;
      drive_cycle(1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
      for (int i = 0; i < count; i++) begin
         send_word(image[6'(i)], 10'(i));
      end
      i_prog_mode = 1'b0;                      // Run follows one cycle later
      @(negedge i_clk);
   endtask

   // One redirect cycle followed by three sequential fetches
   task automatic redirect_fetch(input logic br, input logic j);
      drive_cycle(1'b1, 1'b0, br, bt, j, jt);
      repeat (3) drive_cycle(1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
   endtask

   task automatic report_test(input int num, input string name);
      int errs;
      errs = compare_errors + direct_errors - mark;
      $display("Test %0d %s: %0d errors", num, name, errs);
      mark = compare_errors + direct_errors;
   endtask

   initial begin
      // Programming mode high through reset keeps the core halted afterwards
      i_rst           = 1'b1;
      i_prog_mode     = 1'b1;
      i_byte_stb      = 1'b0;
      i_byte          = 8'h00;
      i_if_id_we      = 1'b1;
      i_flush         = 1'b0;
      i_branch_taken  = 1'b0;
      i_branch_target = 32'h0;
      i_jump          = 1'b0;
      i_jump_target   = 32'h0;
      model_live      = 1'b0;
      for (int i = 0; i < 1024; i++) begin
         model_mem[10'(i)] = 32'h0;
      end
      for (int i = 0; i < IMG_A; i++) begin
         image[6'(i)] = $random(seed);
      end
      repeat (4) @(negedge i_clk);
      i_rst = 1'b0;
      @(negedge i_clk);

      // Test 1 checks the reset values
      direct_checks += 3;
      if (o_instr !== NOP) begin
         $display("CHECK FAILED o_instr expected %08h actual %08h", NOP, o_instr);
         direct_errors++;
      end
      if (o_pc4 !== 32'h0) begin
         $display("CHECK FAILED o_pc4 expected %08h actual %08h", 32'h0, o_pc4);
         direct_errors++;
      end
      if (o_running !== 1'b0) begin
         $display("CHECK FAILED o_running expected %0h actual %0h", 1'b0, o_running);
         direct_errors++;
      end
      report_test(1, "reset values");

      // Test 2 loads the image and fetches it in sequence
      load_image(IMG_A);
      repeat (66) drive_cycle(1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
      report_test(2, "load and sequential fetch");

      // Test 3 jumps back to word 0 and stalls at random
      drive_cycle(1'b1, 1'b0, 1'b0, 32'h0, 1'b1, 32'h0);
      repeat (40) begin
         rnd = $random(seed);
         drive_cycle(rnd[1:0] != 2'b00, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
      end
      report_test(3, "random stalls");

      // Test 4 flushes alone and under stall before a random mix
      drive_cycle(1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0);
      drive_cycle(1'b0, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0);
      repeat (40) begin
         rnd = $random(seed);
         drive_cycle(rnd[4:3] != 2'b00, rnd[2], 1'b0, 32'h0, 1'b0, 32'h0);
      end
      report_test(4, "flush");

      // Test 5 redirects by branch, jump and both to targets inside the image
      rnd = $random(seed);
      bt  = {24'h0, rnd[5:0], 2'b00};
      jt  = bt ^ 32'h40;                       // Sixteen words away
      redirect_fetch(1'b1, 1'b0);
      redirect_fetch(1'b0, 1'b1);
      redirect_fetch(1'b1, 1'b1);
      report_test(5, "branch and jump");

      // Test 6 reloads a shorter image over the start of the first
      for (int i = 0; i < IMG_B; i++) begin
         image[6'(i)] = $random(seed);
      end
      load_image(IMG_B);
      repeat (24) drive_cycle(1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
      report_test(6, "reload");

      $display("Checks %0d, errors %0d", check_count + direct_checks,
               compare_errors + direct_errors);
      if (compare_errors + direct_errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule : tb_fetch_stage

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

// Common definitions for the instruction fetch stage
package fetch_pkg;

   // Datapath widths
   localparam int INSTR_W = 32;          // MIPS instruction word
   localparam int ADDR_W  = 32;          // PC is a full byte address
   localparam int MEM_AW  = 10;          // Word address into the instruction RAM

   // Instruction RAM size in words
   localparam int MEM_DEPTH = 2 ** MEM_AW;

   // Widths that carry a meaning
   typedef logic [INSTR_W-1:0] instr_t;  // One instruction word
   typedef logic [ADDR_W-1:0]  pc_t;     // Byte address with the low two bits zero in use
   typedef logic [MEM_AW-1:0]  maddr_t;  // Word address taken from PC bits 11 to 2
   typedef logic [7:0]         byte_t;   // One byte from the debug loader stream

   // sll $0,$0,0 encodes as all zeros
   // Flush drops this into IF/ID in place of the fetched word
   localparam instr_t NOP_INSTR = '0;

   // Program loader FSM
   typedef enum logic [1:0] {
      LD_IDLE    = 2'd0,                 // Running with the loader quiet
      LD_COLLECT = 2'd1,                 // Gathering bytes of the next word
      LD_WRITE   = 2'd2                  // Single cycle memory write strobe
   } loader_state_t;

endpackage : fetch_pkg

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none

// Instruction fetch stage top
// Loader and fetch share the RAM through separate write and read ports
module fetch_stage (
   input  wire logic             i_clk,
   input  wire logic             i_rst,
   // Debug loader stream
   input  wire logic             i_prog_mode,
   input  wire logic             i_byte_stb,
   input  wire fetch_pkg::byte_t i_byte,
   // Hazard and control unit
   input  wire logic             i_if_id_we,      // Low stalls IF
   input  wire logic             i_flush,         // Insert NOP into IF/ID
   input  wire logic             i_branch_taken,
   input  wire fetch_pkg::pc_t   i_branch_target,
   input  wire logic             i_jump,
   input  wire fetch_pkg::pc_t   i_jump_target,
   // IF/ID boundary
   output fetch_pkg::instr_t     o_instr,
   output fetch_pkg::pc_t        o_pc4,
   output logic                  o_running        // Core out of programming mode
);
   import fetch_pkg::*;

   logic   wr_en;                      // Loader to RAM
   maddr_t wr_addr;
   instr_t wr_data;
   logic   run;                        // Gates PC and RAM read
   maddr_t fetch_addr;                 // PC word address

   prog_loader u_loader (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_prog_mode (i_prog_mode),
      .i_byte_stb  (i_byte_stb),
      .i_byte      (i_byte),
      .o_wr_en     (wr_en),
      .o_wr_addr   (wr_addr),
      .o_wr_data   (wr_data),
      .o_run       (run)
   );

   pc_unit u_pc (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_run           (run),
      .i_if_id_we      (i_if_id_we),
      .i_branch_taken  (i_branch_taken),
      .i_branch_target (i_branch_target),
      .i_jump          (i_jump),
      .i_jump_target   (i_jump_target),
      .o_fetch_addr    (fetch_addr),
      .o_pc4           (o_pc4)
   );

   instr_mem u_imem (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wr_en    (wr_en),
      .i_wr_addr  (wr_addr),
      .i_wr_data  (wr_data),
      .i_rd_addr  (fetch_addr),
      .i_rd_en    (run),
      .i_if_id_we (i_if_id_we),
      .i_flush    (i_flush),
      .o_instr    (o_instr)
   );

   assign o_running = run;

endmodule : fetch_stage

`default_nettype wire

//--- src/instr_mem.sv
`default_nettype none

// Instruction RAM with a write port for the loader and a registered read port for fetch
// The read register is the IF/ID instruction register
module instr_mem (
   input  wire logic             i_clk,
   input  wire logic             i_rst,       // Clears the IF/ID word to NOP only
   input  wire logic             i_wr_en,     // Loader write strobe
   input  wire fetch_pkg::maddr_t i_wr_addr,  // Loader word address
   input  wire fetch_pkg::instr_t i_wr_data,  // Loader word
   input  wire fetch_pkg::maddr_t i_rd_addr,  // Fetch word address from the PC
   input  wire logic             i_rd_en,     // High while the core runs
   input  wire logic             i_if_id_we,  // Low from the hazard unit means stall
   input  wire logic             i_flush,     // Squashes this fetch
   output fetch_pkg::instr_t     o_instr      // IF/ID instruction
);
   import fetch_pkg::*;

   instr_t mem [MEM_DEPTH];             // Program storage
   instr_t instr_q;                     // IF/ID instruction register

   // Memory powers up as zeros so unloaded words read back as NOP
   initial begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Write port used by the loader only
   always_ff @(posedge i_clk) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   // Read port
   // A same-word read and write returns the old contents
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         instr_q <= NOP_INSTR;          // Pipeline starts with a bubble
      end else if (i_rd_en && i_if_id_we) begin
         if (i_flush)
            instr_q <= NOP_INSTR;       // Squashed slot
         else
            instr_q <= mem[i_rd_addr];  // Normal fetch
      end
      // Stalled or not running holds even with flush
   end

   assign o_instr = instr_q;

endmodule : instr_mem

`default_nettype wire

//--- src/pc_unit.sv
`default_nettype none

// Program counter and next-PC select
// Also owns the PC+4 half of the IF/ID register
module pc_unit (
   input  wire logic             i_clk,
   input  wire logic             i_rst,
   input  wire logic             i_run,            // Low while the loader owns the memory
   input  wire logic             i_if_id_we,       // Low means stall
   input  wire logic             i_branch_taken,   // Branch resolved taken
   input  wire fetch_pkg::pc_t   i_branch_target,
   input  wire logic             i_jump,           // Jump with lower priority than branch
   input  wire fetch_pkg::pc_t   i_jump_target,
   output fetch_pkg::maddr_t     o_fetch_addr,     // Word address into the RAM
   output fetch_pkg::pc_t        o_pc4             // IF/ID PC+4
);
   import fetch_pkg::*;

   pc_t pc_q;                          // Current PC
   pc_t pc_plus4;                      // Sequential successor
   pc_t pc_next;                       // Selected next PC
   pc_t pc4_q;                         // IF/ID copy of PC+4

   assign pc_plus4 = pc_q + ADDR_W'(4);

   // Branch wins over jump and jump wins over sequential
   always_comb begin
      if (i_branch_taken)
         pc_next = i_branch_target;
      else if (i_jump)
         pc_next = i_jump_target;
      else
         pc_next = pc_plus4;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q  <= '0;
         pc4_q <= '0;
      end else if (!i_run) begin
         // Parked at address 0 until the loader lets go
         pc_q <= '0;
      end else if (i_if_id_we) begin
         pc_q  <= pc_next;
         pc4_q <= pc_plus4;             // Travels with the word fetched at pc_q
      end
      // Stall holds both
   end

   // Word address from PC bits 11 to 2
   assign o_fetch_addr = pc_q[MEM_AW+1:2];
   assign o_pc4        = pc4_q;

endmodule : pc_unit

`default_nettype wire

//--- src/prog_loader.sv
`default_nettype none

// Debug program loader
// Packs a little-endian byte stream into words and writes them from address 0 upward
// Holds the core out of run while programming mode is on
module prog_loader (
   input  wire logic             i_clk,
   input  wire logic             i_rst,
   input  wire logic             i_prog_mode,   // High while a program is being loaded
   input  wire logic             i_byte_stb,    // One cycle per byte without back-pressure
   input  wire fetch_pkg::byte_t i_byte,
   output logic                  o_wr_en,       // Memory write strobe
   output fetch_pkg::maddr_t     o_wr_addr,     // Memory word address
   output fetch_pkg::instr_t     o_wr_data,     // Assembled word
   output logic                  o_run          // Core may fetch
);
   import fetch_pkg::*;

   loader_state_t state_q;
   logic          prog_q;                       // Last cycle's i_prog_mode
   logic          prog_rise;                    // Programming mode just switched on
   logic [1:0]    byte_cnt_q;                   // Bytes held of the current word
   maddr_t        addr_q;                       // Next word to write
   instr_t        word_q;                       // Word being gathered
   logic          run_q;

   assign prog_rise = i_prog_mode & ~prog_q;

   // Bytes enter at the top and shift down so the first byte ends in bits 7:0
   always_ff @(posedge i_clk) begin
      if (i_byte_stb && i_prog_mode && (state_q != LD_WRITE)) begin
         word_q <= {i_byte, word_q[INSTR_W-1:8]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q    <= LD_IDLE;
         prog_q     <= 1'b0;
         byte_cnt_q <= '0;
         addr_q     <= '0;
         run_q      <= 1'b0;            // Stay halted until mode is seen low
      end else begin
         prog_q <= i_prog_mode;
         run_q  <= ~i_prog_mode;        // Registered inverse of programming mode
         case (state_q)
            LD_IDLE: begin
               if (prog_rise) begin
                  state_q    <= LD_COLLECT;
                  addr_q     <= '0;     // New image always starts at word 0
                  byte_cnt_q <= i_byte_stb ? 2'd1 : 2'd0;
               end
            end
            LD_COLLECT: begin
               if (!i_prog_mode) begin
                  state_q    <= LD_IDLE;
                  byte_cnt_q <= '0;     // Partial word is thrown away
               end else if (i_byte_stb) begin
                  byte_cnt_q <= byte_cnt_q + 2'd1;
                  if (byte_cnt_q == 2'd3)
                     state_q <= LD_WRITE;   // Fourth byte in
               end
            end
            LD_WRITE: begin
               // Write strobe is out this cycle and a byte arriving now is dropped
               addr_q     <= addr_q + MEM_AW'(1);
               byte_cnt_q <= '0;
               state_q    <= i_prog_mode ? LD_COLLECT : LD_IDLE;
            end
            default: state_q <= LD_IDLE;
         endcase
      end
   end

   assign o_wr_en   = (state_q == LD_WRITE);
   assign o_wr_addr = addr_q;
   assign o_wr_data = word_q;
   assign o_run     = run_q;

endmodule : prog_loader

`default_nettype wire

//--- verilog.f
src/fetch_pkg.sv
src/instr_mem.sv
src/pc_unit.sv
src/prog_loader.sv
src/fetch_stage.sv
sim/tb_fetch_stage.sv
